// File: verilog/tlul_bridge_config.svh
`ifndef TLUL_BRIDGE_CONFIG_SVH
`define TLUL_BRIDGE_CONFIG_SVH

// bus widths
`define TLUL_AW 32
`define TLUL_DW 32

// source bit 0 selects the port, the upper bits hold the per-port tag
`define TLUL_SRC_W 2

// outstanding requests allowed per port
`define TLUL_MAX_REQS 2

`endif

// File: verilog/tlul_pkg.sv
`include "tlul_bridge_config.svh"

package tlul_pkg;

  // A-channel opcodes, TL-UL encoding
  typedef enum logic [2:0] {
    PutFullData    = 3'h0,
    PutPartialData = 3'h1,
    Get            = 3'h4
  } tl_a_op_e;

  // D-channel opcodes
  typedef enum logic [2:0] {
    AccessAck     = 3'h0,
    AccessAckData = 3'h1
  } tl_d_op_e;

  // host to device, A channel plus d_ready
  typedef struct packed {
    logic                     a_valid;
    tl_a_op_e                 a_opcode;
    logic [1:0]               a_size;
    logic [`TLUL_SRC_W-1:0]   a_source;
    logic [`TLUL_AW-1:0]      a_address;
    logic [`TLUL_DW/8-1:0]    a_mask;
    logic [`TLUL_DW-1:0]      a_data;
    logic                     d_ready;
  } tl_h2d_t;

  // device to host, D channel plus a_ready
  typedef struct packed {
    logic                     d_valid;
    tl_d_op_e                 d_opcode;
    logic [`TLUL_SRC_W-1:0]   d_source;
    logic [`TLUL_DW-1:0]      d_data;
    logic                     d_error;
    logic                     a_ready;
  } tl_d2h_t;

endpackage

// File: verilog/core_bus_pkg.sv
`include "tlul_bridge_config.svh"

package core_bus_pkg;

  // port index, same value as source bit 0
  typedef enum logic {
    PortInstr = 1'b0,
    PortData  = 1'b1
  } port_e;

  // data port request
  typedef struct packed {
    logic [`TLUL_AW-1:0] addr;
    logic                we;
    logic [3:0]          be;
    logic [`TLUL_DW-1:0] wdata;
  } core_req_t;

  // response back to either port
  typedef struct packed {
    logic [`TLUL_DW-1:0] rdata;
    logic                err;
  } core_rsp_t;

endpackage

// File: verilog/tlul_bridge_ctrl.sv
`timescale 1ns/1ps
`include "tlul_bridge_config.svh"

module tlul_bridge_ctrl #(
  parameter int unsigned MaxReqs = `TLUL_MAX_REQS
) (
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  input  logic                    instr_req_i,
  input  logic                    data_req_i,
  input  logic                    a_ready_i,
  input  logic                    rsp_valid_i,
  input  core_bus_pkg::port_e     rsp_port_i,
  output logic                    instr_gnt_o,
  output logic                    data_gnt_o,
  output logic                    a_valid_o,
  output core_bus_pkg::port_e     sel_port_o,
  output logic [`TLUL_SRC_W-2:0]  tag_o,
  output logic                    alert_o
);

  localparam int unsigned TagW = `TLUL_SRC_W - 1;
  localparam int unsigned CntW = $clog2(MaxReqs + 1);

  // index 0 is the instruction port, 1 the data port
  logic [1:0]           req;
  logic [1:0]           elig;
  logic [1:0]           gnt;
  logic [1:0]           rsp_hit;
  logic [1:0]           cnt_nz;
  logic [1:0][CntW-1:0] cnt_q;
  logic [1:0][TagW-1:0] tag_q;
  logic                 grant;
  logic                 spurious;
  core_bus_pkg::port_e  prio_q;
  core_bus_pkg::port_e  sel_port;
  logic                 alert_q;

  assign req = {data_req_i, instr_req_i};

  // a port may only compete while below its limit
  always_comb begin
    for (int p = 0; p < 2; p++) begin
      elig[p]   = req[p] && (cnt_q[p] < CntW'(MaxReqs));
      cnt_nz[p] = (cnt_q[p] != '0);
    end
  end

  always_comb begin
    if (elig[0] && elig[1]) begin
      sel_port = prio_q;
    end else if (elig[1]) begin
      sel_port = core_bus_pkg::PortData;
    end else begin
      sel_port = core_bus_pkg::PortInstr;
    end
  end

  // a_valid does not wait for a_ready
  assign a_valid_o = |elig;
  assign grant     = a_valid_o && a_ready_i;

  assign gnt[0]     = grant && (sel_port == core_bus_pkg::PortInstr);
  assign gnt[1]     = grant && (sel_port == core_bus_pkg::PortData);
  assign rsp_hit[0] = rsp_valid_i && (rsp_port_i == core_bus_pkg::PortInstr);
  assign rsp_hit[1] = rsp_valid_i && (rsp_port_i == core_bus_pkg::PortData);

  // response for a port with nothing in flight
  assign spurious = |(rsp_hit & ~cnt_nz);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cnt_q   <= '0;
      tag_q   <= '0;
      prio_q  <= core_bus_pkg::PortInstr;
      alert_q <= 1'b0;
    end else begin
      for (int p = 0; p < 2; p++) begin
        if (gnt[p] && !(rsp_hit[p] && cnt_nz[p])) begin
          cnt_q[p] <= cnt_q[p] + 1'b1;
        end else if (!gnt[p] && rsp_hit[p] && cnt_nz[p]) begin
          cnt_q[p] <= cnt_q[p] - 1'b1;
        end
        // tag wraps at the limit so in-flight tags stay unique
        if (gnt[p]) begin
          tag_q[p] <= (tag_q[p] == TagW'(MaxReqs - 1)) ? '0 : tag_q[p] + 1'b1;
        end
      end
      // loser of a contested round gets priority next time
      if (grant && (req == 2'b11)) begin
        prio_q <= (sel_port == core_bus_pkg::PortInstr) ? core_bus_pkg::PortData
                                                          : core_bus_pkg::PortInstr;
      end
      alert_q <= alert_q | spurious;
    end
  end

  assign instr_gnt_o = gnt[0];
  assign data_gnt_o  = gnt[1];
  assign sel_port_o  = sel_port;
  assign tag_o       = (sel_port == core_bus_pkg::PortData) ? tag_q[1] : tag_q[0];
  assign alert_o     = alert_q;

  for (genvar p = 0; p < 2; p++) begin : g_port_chk
    a_cnt_limit: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      cnt_q[p] <= CntW'(MaxReqs));

    // a grant goes only to a requesting port below its limit while the fabric is ready
    a_gnt_needs_ready: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      gnt[p] |-> (a_ready_i && req[p] && (cnt_q[p] < CntW'(MaxReqs))));
  end

endmodule

// File: verilog/tlul_a_packer.sv
`timescale 1ns/1ps
`include "tlul_bridge_config.svh"

module tlul_a_packer (
  input  core_bus_pkg::port_e        sel_port_i,
  input  logic [`TLUL_SRC_W-2:0]     tag_i,
  input  logic [`TLUL_AW-1:0]        instr_addr_i,
  input  core_bus_pkg::core_req_t    data_req_i,
  input  logic                       a_valid_i,
  output tlul_pkg::tl_h2d_t          tl_a_o
);

  localparam int unsigned MaskW = `TLUL_DW / 8;

  logic fetch;

  assign fetch = (sel_port_i == core_bus_pkg::PortInstr);

  always_comb begin
    tl_a_o          = '0;
    tl_a_o.a_valid  = a_valid_i;
    // always a full word
    tl_a_o.a_size   = 2'd2;
    tl_a_o.a_source = {tag_i, sel_port_i};
    tl_a_o.d_ready  = 1'b1;
    if (fetch) begin
      tl_a_o.a_opcode  = tlul_pkg::Get;
      tl_a_o.a_address = {instr_addr_i[`TLUL_AW-1:2], 2'b00};
      tl_a_o.a_mask    = {MaskW{1'b1}};
    end else begin
      tl_a_o.a_address = {data_req_i.addr[`TLUL_AW-1:2], 2'b00};
      tl_a_o.a_mask    = data_req_i.be;
      tl_a_o.a_data    = data_req_i.wdata;
      if (!data_req_i.we) begin
        tl_a_o.a_opcode = tlul_pkg::Get;
      end else if (&data_req_i.be) begin
        tl_a_o.a_opcode = tlul_pkg::PutFullData;
      end else begin
        tl_a_o.a_opcode = tlul_pkg::PutPartialData;
      end
    end
  end

endmodule

// File: verilog/tlul_d_unpacker.sv
`timescale 1ns/1ps
`include "tlul_bridge_config.svh"

module tlul_d_unpacker (
  input  tlul_pkg::tl_d2h_t         tl_d_i,
  output logic                      instr_rvalid_o,
  output logic                      data_rvalid_o,
  output core_bus_pkg::core_rsp_t   instr_rsp_o,
  output core_bus_pkg::core_rsp_t   data_rsp_o,
  output logic                      rsp_valid_o,
  output core_bus_pkg::port_e       rsp_port_o
);

  core_bus_pkg::core_rsp_t rsp;
  logic                    ack_with_data;

  // port lives in source bit 0
  assign rsp_port_o  = core_bus_pkg::port_e'(tl_d_i.d_source[0]);
  assign rsp_valid_o = tl_d_i.d_valid;

  // a write ack must not return data
  assign ack_with_data = (tl_d_i.d_opcode == tlul_pkg::AccessAck) &&
                         (tl_d_i.d_data != '0);

  assign rsp.rdata = tl_d_i.d_data;
  assign rsp.err   = tl_d_i.d_error | ack_with_data;

  assign instr_rsp_o = rsp;
  assign data_rsp_o  = rsp;

  assign instr_rvalid_o = tl_d_i.d_valid && (rsp_port_o == core_bus_pkg::PortInstr);
  assign data_rvalid_o  = tl_d_i.d_valid && (rsp_port_o == core_bus_pkg::PortData);

  // only AccessAck and AccessAckData are legal on this link
  always_comb begin
    if (tl_d_i.d_valid) begin
      a_d_opcode: assert final (tl_d_i.d_opcode inside {tlul_pkg::AccessAck,
                                                      tlul_pkg::AccessAckData})
        else $error("illegal D opcode %0h", tl_d_i.d_opcode);
    end
  end

endmodule

// File: verilog/tlul_core_bridge.sv
`timescale 1ns/1ps
`include "tlul_bridge_config.svh"

module tlul_core_bridge (
  input  logic                      clk_i,
  input  logic                      arst_n_i,

  // instruction port
  input  logic                      instr_req_i,
  input  logic [`TLUL_AW-1:0]       instr_addr_i,
  output logic                      instr_gnt_o,
  output logic                      instr_rvalid_o,
  output core_bus_pkg::core_rsp_t   instr_rsp_o,

  // data port
  input  logic                      data_req_i,
  input  core_bus_pkg::core_req_t   data_req_data_i,
  output logic                      data_gnt_o,
  output logic                      data_rvalid_o,
  output core_bus_pkg::core_rsp_t   data_rsp_o,

  // TL-UL host port
  output tlul_pkg::tl_h2d_t         tl_o,
  input  tlul_pkg::tl_d2h_t         tl_i,

  output logic                      alert_o
);

  logic                         a_valid;
  core_bus_pkg::port_e          sel_port;
  logic [`TLUL_SRC_W-2:0]       tag;
  logic                         rsp_valid;
  core_bus_pkg::port_e          rsp_port;

  tlul_bridge_ctrl #(
    .MaxReqs (`TLUL_MAX_REQS)
  ) ctrl_i (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .instr_req_i (instr_req_i),
    .data_req_i  (data_req_i),
    .a_ready_i   (tl_i.a_ready),
    .rsp_valid_i (rsp_valid),
    .rsp_port_i  (rsp_port),
    .instr_gnt_o (instr_gnt_o),
    .data_gnt_o  (data_gnt_o),
    .a_valid_o   (a_valid),
    .sel_port_o  (sel_port),
    .tag_o       (tag),
    .alert_o     (alert_o)
  );

  // A channel, a_valid folded into the host struct here
  tlul_a_packer a_packer_i (
    .sel_port_i   (sel_port),
    .tag_i        (tag),
    .instr_addr_i (instr_addr_i),
    .data_req_i   (data_req_data_i),
    .a_valid_i    (a_valid),
    .tl_a_o       (tl_o)
  );

  tlul_d_unpacker d_unpacker_i (
    .tl_d_i         (tl_i),
    .instr_rvalid_o (instr_rvalid_o),
    .data_rvalid_o  (data_rvalid_o),
    .instr_rsp_o    (instr_rsp_o),
    .data_rsp_o     (data_rsp_o),
    .rsp_valid_o    (rsp_valid),
    .rsp_port_o     (rsp_port)
  );

endmodule

// File: testbench/tb_tlul_mem.sv
`timescale 1ns/1ps
`include "tlul_bridge_config.svh"

module tb_tlul_mem #(
  parameter logic [`TLUL_AW-1:0] ErrBase = 32'hffff_f000,
  parameter int                  Seed    = 32'hacab_3dd6
) (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  tlul_pkg::tl_h2d_t      tl_i,
  output tlul_pkg::tl_d2h_t      tl_o,
  input  logic                   inject_i,
  input  logic [`TLUL_SRC_W-1:0] inject_src_i
);

  typedef struct packed {
    logic [31:0]            due;
    logic [`TLUL_SRC_W-1:0] source;
    tlul_pkg::tl_d_op_e     op;
    logic [`TLUL_DW-1:0]    data;
    logic                   err;
  } pend_t;

  logic [`TLUL_DW-1:0] mem [logic [`TLUL_AW-1:0]];
  pend_t               pend_q[$];
  pend_t               head;
  pend_t               acc;
  tlul_pkg::tl_d2h_t   d2h_q;
  int                  seed = Seed;
  logic [31:0]         cyc;

  assign tl_o = d2h_q;

  // unwritten words read back as a mix of their own address
  function automatic logic [`TLUL_DW-1:0] fill_word(input logic [`TLUL_AW-1:0] addr);
    return addr ^ {addr[15:0], addr[31:16]} ^ 32'h3c5a_96e1;
  endfunction

  function automatic pend_t serve(input tlul_pkg::tl_h2d_t a);
    pend_t               e;
    logic [`TLUL_DW-1:0] word;
    e        = '0;
    e.source = a.a_source;
    e.err    = (a.a_address >= ErrBase);
    e.op     = (a.a_opcode == tlul_pkg::Get) ? tlul_pkg::AccessAckData : tlul_pkg::AccessAck;
    word     = mem.exists(a.a_address) ? mem[a.a_address] : fill_word(a.a_address);
    if (!e.err && a.a_opcode == tlul_pkg::Get) begin
      e.data = word;
    end else if (!e.err) begin
      for (int b = 0; b < `TLUL_DW / 8; b++) begin
        if (a.a_mask[b])
          word[8*b +: 8] = a.a_data[8*b +: 8];
      end
      mem[a.a_address] = word;
    end
    return e;
  endfunction

  always @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      d2h_q <= '0;
      cyc   <= '0;
      pend_q.delete();
    end else begin
      cyc           <= cyc + 1;
      d2h_q.a_ready <= ($random(seed) & 3) != 0;
      d2h_q.d_valid <= 1'b0;
      // injected response takes the slot, queue waits a cycle
      if (inject_i) begin
        d2h_q.d_valid  <= 1'b1;
        d2h_q.d_opcode <= tlul_pkg::AccessAckData;
        d2h_q.d_source <= inject_src_i;
        d2h_q.d_data   <= '0;
        d2h_q.d_error  <= 1'b0;
      end else if (pend_q.size() != 0 && pend_q[0].due <= cyc) begin
        head = pend_q.pop_front();
        d2h_q.d_valid  <= 1'b1;
        d2h_q.d_opcode <= head.op;
        d2h_q.d_source <= head.source;
        d2h_q.d_data   <= head.data;
        d2h_q.d_error  <= head.err;
      end
      // accept on the same edge the bridge sees its grant
      if (tl_i.a_valid && d2h_q.a_ready) begin
        acc     = serve(tl_i);
        acc.due = cyc + ($unsigned($random(seed)) % 5);
        pend_q.push_back(acc);
      end
    end
  end

endmodule

// File: testbench/tb_tlul_core_bridge.sv
`timescale 1ns/1ps
`include "tlul_bridge_config.svh"

module tb_tlul_core_bridge;

  localparam logic [`TLUL_AW-1:0] Base    = 32'h0000_1000;
  localparam logic [`TLUL_AW-1:0] ErrBase = 32'hffff_f000;
  localparam int                  Timeout = 200;

  logic                    clk_i;
  logic                    arst_n_i;
  logic                    instr_req_i;
  logic [`TLUL_AW-1:0]     instr_addr_i;
  logic                    instr_gnt_o;
  logic                    instr_rvalid_o;
  core_bus_pkg::core_rsp_t instr_rsp_o;
  logic                    data_req_i;
  core_bus_pkg::core_req_t data_req_data_i;
  logic                    data_gnt_o;
  logic                    data_rvalid_o;
  core_bus_pkg::core_rsp_t data_rsp_o;
  tlul_pkg::tl_h2d_t       tl_o;
  tlul_pkg::tl_d2h_t       tl_i;
  logic                    alert_o;
  logic                    inject;

  // expected memory contents, keyed by word address
  logic [`TLUL_DW-1:0]     shadow [logic [`TLUL_AW-1:0]];
  core_bus_pkg::core_req_t instr_stim[$];
  core_bus_pkg::core_req_t data_stim[$];
  core_bus_pkg::core_rsp_t instr_exp_q[$];
  core_bus_pkg::core_rsp_t data_exp_q[$];
  int                      outst[2] = '{0, 0};
  int                      tag_cnt[2] = '{0, 0};
  int                      rsp_errs = 0;
  int                      a_errs = 0;
  int                      alert_errs = 0;
  int                      proto_errs = 0;
  bit                      spurious_ok = 1'b0;
  int                      seed = 32'hacab_3dd6;

  always #2 clk_i = ~clk_i;

  tlul_core_bridge tlul_core_bridge_i (.*);

  tb_tlul_mem #(.ErrBase(ErrBase), .Seed(32'hacab_3dd6)) mem_i (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .tl_i         (tl_o),
    .tl_o         (tl_i),
    .inject_i     (inject),
    .inject_src_i ('0)
  );

  function automatic logic [`TLUL_DW-1:0] fill_word(input logic [`TLUL_AW-1:0] addr);
    return addr ^ {addr[15:0], addr[31:16]} ^ 32'h3c5a_96e1;
  endfunction

  function automatic core_bus_pkg::core_rsp_t ref_access(input core_bus_pkg::core_req_t req);
    core_bus_pkg::core_rsp_t rsp;
    logic [`TLUL_AW-1:0]     a;
    logic [`TLUL_DW-1:0]     word;
    a    = {req.addr[`TLUL_AW-1:2], 2'b00};
    word = shadow.exists(a) ? shadow[a] : fill_word(a);
    rsp  = '0;
    if (a >= ErrBase) begin
      rsp.err = 1'b1;
    end else if (!req.we) begin
      rsp.rdata = word;
    end else begin
      // merge under the byte enables
      for (int b = 0; b < 4; b++) begin
        if (req.be[b])
          word[8*b +: 8] = req.wdata[8*b +: 8];
      end
      shadow[a] = word;
    end
    return rsp;
  endfunction

  // A message that a granted request should produce
  function automatic tlul_pkg::tl_h2d_t a_expect(input core_bus_pkg::port_e port,
                                                 input core_bus_pkg::core_req_t req,
                                                 input int tag);
    tlul_pkg::tl_h2d_t a;
    a           = '0;
    a.a_valid   = 1'b1;
    a.a_size    = 2'd2;
    a.a_source  = `TLUL_SRC_W'((tag << 1) | int'(port));
    a.a_address = req.addr & ~32'h3;
    a.a_mask    = (port == core_bus_pkg::PortInstr) ? 4'hf : req.be;
    a.a_data    = req.wdata;
    a.d_ready   = 1'b1;
    if (port == core_bus_pkg::PortInstr || !req.we)
      a.a_opcode = tlul_pkg::Get;
    else if (req.be == 4'hf)
      a.a_opcode = tlul_pkg::PutFullData;
    else
      a.a_opcode = tlul_pkg::PutPartialData;
    return a;
  endfunction

  function automatic core_bus_pkg::core_req_t rand_req(input logic [`TLUL_AW-1:0] base,
                                                       input bit fetch);
    core_bus_pkg::core_req_t r;
    // 32 words at random byte offsets so reads often hit earlier writes
    r.addr  = base + (32'($random(seed)) & 32'h7f);
    r.we    = fetch ? 1'b0 : 1'($random(seed));
    r.be    = fetch ? 4'hf : 4'($random(seed));
    r.wdata = 32'($random(seed));
    return r;
  endfunction

  task automatic queue_mix(input int n, input logic [`TLUL_AW-1:0] base);
    repeat (n) begin
      instr_stim.push_back(rand_req(base, 1'b1));
      data_stim.push_back(rand_req(base, 1'b0));
    end
  endtask

  task automatic check_rsp(input string name, input core_bus_pkg::core_rsp_t got,
                           input core_bus_pkg::core_rsp_t exp);
    if (got !== exp) begin
      rsp_errs++;
      $display("CHECK FAILED at %0t: %s got rdata=%h err=%b, expected rdata=%h err=%b",
               $time, name, got.rdata, got.err, exp.rdata, exp.err);
    end
  endtask

  // a_data only matters for writes
  task automatic check_a(input string name, input tlul_pkg::tl_h2d_t got,
                         input tlul_pkg::tl_h2d_t exp, input bit with_data);
    tlul_pkg::tl_h2d_t cmp;
    cmp = got;
    if (!with_data)
      cmp.a_data = exp.a_data;
    if (cmp !== exp) begin
      a_errs++;
      $display("CHECK FAILED at %0t: %s got %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_alert(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      alert_errs++;
      $display("CHECK FAILED at %0t: %s got %b, expected %b", $time, name, got, exp);
    end
  endtask

  // hold the request until granted, then record what should come back
  task automatic drive(input core_bus_pkg::port_e port, input core_bus_pkg::core_req_t req);
    int   waited;
    logic got;
    waited = 0;
    @(negedge clk_i);
    if (port == core_bus_pkg::PortData) begin
      data_req_i      = 1'b1;
      data_req_data_i = req;
    end else begin
      instr_req_i  = 1'b1;
      instr_addr_i = req.addr;
    end
    do begin
      @(posedge clk_i);
      waited++;
      got = (port == core_bus_pkg::PortData) ? data_gnt_o : instr_gnt_o;
    end while (!got && waited < Timeout);
    if (!got) begin
      proto_errs++;
      $display("%0t: request to %h was never granted", $time, req.addr);
    end else begin
      check_a("tl_o", tl_o, a_expect(port, req, tag_cnt[int'(port)]),
              port == core_bus_pkg::PortData && req.we);
      tag_cnt[int'(port)] = (tag_cnt[int'(port)] + 1) % `TLUL_MAX_REQS;
      if (port == core_bus_pkg::PortData)
        data_exp_q.push_back(ref_access(req));
      else
        instr_exp_q.push_back(ref_access(req));
    end
  endtask

  task automatic run_traffic();
    int waited;
    fork
      begin
        while (instr_stim.size() != 0)
          drive(core_bus_pkg::PortInstr, instr_stim.pop_front());
        @(negedge clk_i);
        instr_req_i = 1'b0;
      end
      begin
        while (data_stim.size() != 0)
          drive(core_bus_pkg::PortData, data_stim.pop_front());
        @(negedge clk_i);
        data_req_i = 1'b0;
      end
    join
    waited = 0;
    while (instr_exp_q.size() + data_exp_q.size() != 0 && waited < Timeout) begin
      @(posedge clk_i);
      waited++;
    end
    if (instr_exp_q.size() + data_exp_q.size() != 0) begin
      proto_errs++;
      $display("%0t: responses still missing after %0d cycles", $time, Timeout);
    end
  endtask

  task automatic take_rsp(input core_bus_pkg::port_e p, input string name,
                          input core_bus_pkg::core_rsp_t got);
    int n;
    n = (p == core_bus_pkg::PortData) ? data_exp_q.size() : instr_exp_q.size();
    if (n != 0) begin
      outst[int'(p)]--;
      check_rsp(name, got, (p == core_bus_pkg::PortData) ? data_exp_q.pop_front()
                                                          : instr_exp_q.pop_front());
    end else if (spurious_ok) begin
      spurious_ok = 1'b0;
    end else begin
      proto_errs++;
      $display("%0t: response on %s with nothing outstanding", $time, name);
    end
  endtask

  // compares every response and tracks grants minus responses per port
  always @(posedge clk_i) begin
    if (arst_n_i) begin
      outst[0] += int'(instr_gnt_o);
      outst[1] += int'(data_gnt_o);
      if (instr_rvalid_o)
        take_rsp(core_bus_pkg::PortInstr, "instr_rsp_o", instr_rsp_o);
      if (data_rvalid_o)
        take_rsp(core_bus_pkg::PortData, "data_rsp_o", data_rsp_o);
      if (outst[0] > `TLUL_MAX_REQS || outst[1] > `TLUL_MAX_REQS) begin
        proto_errs++;
        $display("%0t: more than %0d requests outstanding on one port", $time,
                 `TLUL_MAX_REQS);
      end
    end
  end

  initial begin
    core_bus_pkg::core_req_t req;
    int                      waited;
    clk_i           = 1'b0;
    arst_n_i        = 1'b0;
    instr_req_i     = 1'b0;
    instr_addr_i    = '0;
    data_req_i      = 1'b0;
    data_req_data_i = '0;
    inject          = 1'b0;
    repeat (3) @(posedge clk_i);
    check_alert("alert_o", alert_o, 1'b0);
    @(negedge clk_i);
    arst_n_i = 1'b1;
    // write then read back, the first pair with all byte enables
    for (int i = 0; i < 17; i++) begin
      req    = rand_req(Base, 1'b0);
      req.we = 1'b1;
      if (i == 0)
        req.be = 4'hf;
      data_stim.push_back(req);
      req.we = 1'b0;
      data_stim.push_back(req);
    end
    run_traffic();
    queue_mix(40, Base);
    run_traffic();
    queue_mix(4, ErrBase);
    run_traffic();
    // one response the instruction port never asked for
    check_alert("alert_o", alert_o, 1'b0);
    spurious_ok = 1'b1;
    @(negedge clk_i);
    inject = 1'b1;
    @(negedge clk_i);
    inject = 1'b0;
    waited = 0;
    while (!alert_o && waited < Timeout) begin
      @(posedge clk_i);
      waited++;
    end
    check_alert("alert_o", alert_o, 1'b1);
    queue_mix(20, Base);
    run_traffic();
    check_alert("alert_o", alert_o, 1'b1);
    if (spurious_ok) begin
      proto_errs++;
      $display("injected response never reached the instruction port");
    end
    $display("errors: %0d response, %0d A-channel, %0d alert, %0d protocol",
             rsp_errs, a_errs, alert_errs, proto_errs);
    if (rsp_errs + a_errs + alert_errs + proto_errs == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: src.f
+incdir+verilog
verilog/tlul_pkg.sv
verilog/core_bus_pkg.sv
verilog/tlul_bridge_ctrl.sv
verilog/tlul_a_packer.sv
verilog/tlul_d_unpacker.sv
verilog/tlul_core_bridge.sv
testbench/tb_tlul_mem.sv
testbench/tb_tlul_core_bridge.sv

// File: Bender.yml
package:
  name: tlul_core_bridge

export_include_dirs:
  - verilog

sources:
  - verilog/tlul_pkg.sv
  - verilog/core_bus_pkg.sv
  - verilog/tlul_bridge_ctrl.sv
  - verilog/tlul_a_packer.sv
  - verilog/tlul_d_unpacker.sv
  - verilog/tlul_core_bridge.sv
  - target: test
    files:
      - testbench/tb_tlul_mem.sv
      - testbench/tb_tlul_core_bridge.sv
